// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       ?= cpu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# the ROM image is read from the working directory
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	cd verification && ../$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
logic/core_cfg_pkg.sv
logic/rv_isa_pkg.sv
logic/ctrl_if.sv
logic/decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/data_mem.sv
logic/cpu_top.sv
verification/cpu_props.sv
verification/cpu_tb.sv

// File: logic/alu.sv
// shift amount is taken from the low 5 bits of src2; compares are signed only
module alu (
    input  logic [core_cfg_pkg::XLEN-1:0] src1_i,
    input  logic [core_cfg_pkg::XLEN-1:0] src2_i,
    input  logic [core_cfg_pkg::XLEN-1:0] rs1_val_i,
    input  logic [core_cfg_pkg::XLEN-1:0] rs2_val_i,
    ctrl_if.datapath                      ctrl,
    output logic [core_cfg_pkg::XLEN-1:0] result_o,
    output logic                          take_o
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic       cond;
    logic [4:0] shamt;

    assign shamt = src2_i[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    result_o = src1_i + src2_i;
            ALU_SUB:    result_o = src1_i - src2_i;
            ALU_AND:    result_o = src1_i & src2_i;
            ALU_OR:     result_o = src1_i | src2_i;
            ALU_XOR:    result_o = src1_i ^ src2_i;
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
            ALU_SLL:    result_o = src1_i << shamt;
            ALU_SRL:    result_o = src1_i >> shamt;
            ALU_SRA:    result_o = $unsigned($signed(src1_i) >>> shamt);
            ALU_PASS_B: result_o = src2_i;    // lui
            default:    result_o = '0;
        endcase
    end

    // branch test always on the raw register values
    always_comb begin
        case (ctrl.branch)
            BR_EQ:   cond = (rs1_val_i == rs2_val_i);
            BR_NE:   cond = (rs1_val_i != rs2_val_i);
            BR_LT:   cond = ($signed(rs1_val_i) < $signed(rs2_val_i));
            default: cond = ($signed(rs1_val_i) >= $signed(rs2_val_i));
        endcase
    end

    assign take_o = (ctrl.next_pc == NPC_JAL) || (ctrl.next_pc == NPC_JALR) ||
                    ((ctrl.next_pc == NPC_BRANCH) && cond);

endmodule

// File: logic/core_cfg_pkg.sv
// RV32 only; 16-bit PC and byte addresses, ROM and RAM are word arrays indexed from address bit 2
package core_cfg_pkg;

    // datapath
    localparam int XLEN = 32;

    // address space, byte addressed
    localparam int PC_WIDTH   = 16;
    localparam int IMEM_WORDS = 256;    // 1 KiB of program
    localparam int DMEM_WORDS = 256;    // 1 KiB of data

    // first fetch after reset
    localparam logic [PC_WIDTH-1:0] RESET_PC = '0;

    // program image, read relative to the simulator's working dir
    localparam string IMEM_FILE = "program.hex";

endpackage

// File: logic/cpu_top.sv
// single-cycle core; the first instruction executes one cycle after reset release, ROM from IMEM_FILE
module cpu_top (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    output logic                              retire_valid_o,
    output logic [core_cfg_pkg::PC_WIDTH-1:0] retire_pc_o,
    output logic [core_cfg_pkg::XLEN-1:0]     retire_instr_o,
    output logic                              retire_we_o,
    output logic [4:0]                        retire_rd_o,
    output logic [core_cfg_pkg::XLEN-1:0]     retire_wdata_o,
    output logic                              dmem_we_o,
    output logic [core_cfg_pkg::PC_WIDTH-1:0] dmem_addr_o,
    output logic [core_cfg_pkg::XLEN-1:0]     dmem_wdata_o
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    localparam int IAW = $clog2(IMEM_WORDS);

    logic [PC_WIDTH-1:0] pc_q, pc_next, pc_plus4, jump_target;
    logic                run_q;    // low in reset and the cycle after
    logic [XLEN-1:0]     instr, rs1_val, rs2_val;
    logic [XLEN-1:0]     alu_a, alu_b, alu_res;
    logic [XLEN-1:0]     dmem_rd, load_data, wb_data;
    logic                take, reg_we, mem_we;
    logic [XLEN-1:0]     imem [IMEM_WORDS];

    initial $readmemh(IMEM_FILE, imem);

    assign instr = imem[pc_q[IAW+1:2]];

    ctrl_if ctrl ();

    decoder u_decoder (.instr_i(instr), .ctrl(ctrl));

    reg_file u_reg_file (
        .clk_i (clk_i),
        .ad1_i (ctrl.rs1),
        .ad2_i (ctrl.rs2),
        .ad3_i (ctrl.rd),
        .we3_i (reg_we),
        .wd3_i (wb_data),
        .rd1_o (rs1_val),
        .rd2_o (rs2_val)
    );

    always_comb begin
        case (ctrl.src1)
            SRC1_RS1: alu_a = rs1_val;
            SRC1_PC:  alu_a = {{(XLEN-PC_WIDTH){1'b0}}, pc_q};
            default:  alu_a = '0;
        endcase
    end
    assign alu_b = (ctrl.src2 == SRC2_RS2) ? rs2_val : ctrl.imm;

    alu u_alu (
        .src1_i    (alu_a),
        .src2_i    (alu_b),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .ctrl      (ctrl),
        .result_o  (alu_res),
        .take_o    (take)
    );

    data_mem u_data_mem (
        .clk_i (clk_i),
        .a_i   (alu_res[PC_WIDTH-1:0]),
        .wd_i  (rs2_val),
        .wen_i (mem_we),
        .rd_o  (dmem_rd)
    );

    assign load_data = ctrl.mem_read ? dmem_rd : '0;    // zero unless a load

    always_comb begin
        case (ctrl.srcr)
            SRCR_MEM:     wb_data = load_data;
            SRCR_NEXT_PC: wb_data = {{(XLEN-PC_WIDTH){1'b0}}, pc_plus4};    // link address
            default:      wb_data = alu_res;
        endcase
    end

    // writes only once the core runs
    assign reg_we = run_q && ctrl.reg_write && (ctrl.rd != 5'd0);
    assign mem_we = run_q && ctrl.mem_write;

    // next PC
    assign pc_plus4    = pc_q + PC_WIDTH'(4);
    assign jump_target = pc_q + ctrl.imm[PC_WIDTH-1:0];    // branch and jal
    always_comb begin
        if (!take)
            pc_next = pc_plus4;
        else if (ctrl.next_pc == NPC_JALR)
            pc_next = {alu_res[PC_WIDTH-1:1], 1'b0};
        else
            pc_next = jump_target;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q  <= RESET_PC;
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (run_q)
                pc_q <= pc_next;    // hold RESET_PC for the first run cycle
        end
    end

    // trace
    assign retire_valid_o = run_q;
    assign retire_pc_o    = pc_q;
    assign retire_instr_o = instr;
    assign retire_we_o    = reg_we;
    assign retire_rd_o    = ctrl.rd;
    assign retire_wdata_o = wb_data;
    assign dmem_we_o      = mem_we;
    assign dmem_addr_o    = alu_res[PC_WIDTH-1:0];
    assign dmem_wdata_o   = rs2_val;

endmodule

// File: logic/ctrl_if.sv
// one decoded instruction per cycle; every field is combinational from the current instruction word
interface ctrl_if;
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    alu_op_t   alu_op;
    src1_t     src1;
    src2_t     src2;
    srcr_t     srcr;        // writeback source
    next_pc_t  next_pc;
    branch_t   branch;

    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;   // already sign extended

    logic reg_write;
    logic mem_read;
    logic mem_write;

    modport decoder (
        output alu_op, src1, src2, srcr, next_pc, branch,
        output rs1, rs2, rd, imm,
        output reg_write, mem_read, mem_write
    );

    modport datapath (
        input alu_op, src1, src2, srcr, next_pc, branch,
        input rs1, rs2, rd, imm,
        input reg_write, mem_read, mem_write
    );

endinterface

// File: logic/data_mem.sv
// word access only; the two low address bits are ignored and addresses past the RAM depth alias
module data_mem (
    input  logic                              clk_i,
    input  logic [core_cfg_pkg::PC_WIDTH-1:0] a_i,     // byte address
    input  logic [core_cfg_pkg::XLEN-1:0]     wd_i,
    input  logic                              wen_i,
    output logic [core_cfg_pkg::XLEN-1:0]     rd_o
);
    import core_cfg_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic [AW-1:0]   word_addr;

    // start from a clean image in simulation
    initial begin
        for (int i = 0; i < DMEM_WORDS; i++)
            mem[i] = '0;
    end

    assign word_addr = a_i[AW+1:2];

    always_ff @(posedge clk_i) begin
        if (wen_i)
            mem[word_addr] <= wd_i;
    end

    assign rd_o = mem[word_addr];    // async read, same cycle as address

endmodule

// File: logic/decoder.sv
// unsupported opcodes and funct codes decode to a no-op: no writes and sequential next PC
module decoder (
    input  logic [core_cfg_pkg::XLEN-1:0] instr_i,
    ctrl_if.decoder                       ctrl
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    opcode_t         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // immediate formats, bit 31 is always the sign
    assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        ctrl.rs1       = instr_i[19:15];
        ctrl.rs2       = instr_i[24:20];
        ctrl.rd        = instr_i[11:7];
        ctrl.alu_op    = ALU_ADD;
        ctrl.src1      = SRC1_RS1;
        ctrl.src2      = SRC2_IMM;
        ctrl.srcr      = SRCR_ALU;
        ctrl.next_pc   = NPC_SEQ;
        ctrl.branch    = branch_t'({funct3[2], funct3[0]});
        ctrl.imm       = imm_i;
        ctrl.reg_write = 1'b0;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;

        case (opcode)
            OP_LUI: begin
                ctrl.src1      = SRC1_ZERO;
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.imm       = imm_u;
                ctrl.reg_write = 1'b1;
            end
            OP_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    F3_ADD:  ctrl.alu_op = ALU_ADD;
                    F3_SLT:  ctrl.alu_op = ALU_SLT;
                    F3_XOR:  ctrl.alu_op = ALU_XOR;
                    F3_OR:   ctrl.alu_op = ALU_OR;
                    F3_AND:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0;    // slli, srli, srai, sltiu
                endcase
            end
            OP_OP: begin
                ctrl.src2      = SRC2_RS2;
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}: ctrl.alu_op = ALU_ADD;
                    {F7_ALT, F3_ADD}:  ctrl.alu_op = ALU_SUB;
                    {F7_BASE, F3_SLL}: ctrl.alu_op = ALU_SLL;
                    {F7_BASE, F3_SLT}: ctrl.alu_op = ALU_SLT;
                    {F7_BASE, F3_XOR}: ctrl.alu_op = ALU_XOR;
                    {F7_BASE, F3_SR}:  ctrl.alu_op = ALU_SRL;
                    {F7_ALT, F3_SR}:   ctrl.alu_op = ALU_SRA;
                    {F7_BASE, F3_OR}:  ctrl.alu_op = ALU_OR;
                    {F7_BASE, F3_AND}: ctrl.alu_op = ALU_AND;
                    default:           ctrl.reg_write = 1'b0;
                endcase
            end
            OP_LOAD: begin
                if (funct3 == F3_LW) begin    // word loads only
                    ctrl.srcr      = SRCR_MEM;
                    ctrl.mem_read  = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
            end
            OP_STORE: begin
                ctrl.imm       = imm_s;
                ctrl.mem_write = (funct3 == F3_SW);
            end
            OP_BRANCH: begin
                ctrl.src2 = SRC2_RS2;
                ctrl.imm  = imm_b;
                // funct3[1] set means bltu/bgeu
                if (!funct3[1])
                    ctrl.next_pc = NPC_BRANCH;
            end
            OP_JAL: begin
                ctrl.src1      = SRC1_PC;    // alu result mirrors the target
                ctrl.imm       = imm_j;
                ctrl.srcr      = SRCR_NEXT_PC;
                ctrl.next_pc   = NPC_JAL;
                ctrl.reg_write = 1'b1;
            end
            OP_JALR: begin
                ctrl.srcr      = SRCR_NEXT_PC;
                ctrl.next_pc   = NPC_JALR;
                ctrl.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/reg_file.sv
// x0 is hardwired to zero; reads are combinational so a same-cycle write shows on the next cycle
module reg_file (
    input  logic                          clk_i,
    input  logic [4:0]                    ad1_i,
    input  logic [4:0]                    ad2_i,
    input  logic [4:0]                    ad3_i,
    input  logic                          we3_i,
    input  logic [core_cfg_pkg::XLEN-1:0] wd3_i,
    output logic [core_cfg_pkg::XLEN-1:0] rd1_o,
    output logic [core_cfg_pkg::XLEN-1:0] rd2_o
);
    import core_cfg_pkg::*;

    logic [XLEN-1:0] regs [32];    // entry 0 never written

    always_ff @(posedge clk_i) begin
        if (we3_i && (ad3_i != 5'd0))
            regs[ad3_i] <= wd3_i;
    end

    assign rd1_o = (ad1_i == 5'd0) ? '0 : regs[ad1_i];
    assign rd2_o = (ad2_i == 5'd0) ? '0 : regs[ad2_i];

endmodule

// File: logic/rv_isa_pkg.sv
// covers only the supported RV32I subset; unsigned compares, shift-immediates and AUIPC are absent
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_OP_IMM = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {SRC1_RS1, SRC1_ZERO, SRC1_PC} src1_t;
    typedef enum logic {SRC2_RS2, SRC2_IMM} src2_t;
    typedef enum logic [1:0] {SRCR_ALU, SRCR_MEM, SRCR_NEXT_PC} srcr_t;
    typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JAL, NPC_JALR} next_pc_t;

    // encoded as {funct3[2], funct3[0]} of the branch
    typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT, BR_GE} branch_t;

    // funct3 / funct7 codes
    localparam logic [2:0] F3_ADD = 3'b000;    // add, sub
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;    // srl, sra
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // sub, sra

endpackage

// File: verification/cpu_props.sv
// sees only the trace ports of cpu_top; the program must stay within the supported subset
module cpu_props (
    input logic                              clk_i,
    input logic                              rst_n_i,
    input logic                              valid_i,
    input logic [core_cfg_pkg::PC_WIDTH-1:0] pc_i,
    input logic [core_cfg_pkg::XLEN-1:0]     instr_i,
    input logic                              we_i,
    input logic [4:0]                        rd_i,
    input logic [core_cfg_pkg::XLEN-1:0]     wdata_i,
    input logic                              dmem_we_i,
    input logic [core_cfg_pkg::PC_WIDTH-1:0] dmem_addr_i,
    input logic [core_cfg_pkg::XLEN-1:0]     dmem_wdata_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import core_cfg_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    int err_count = 0;    // polled by the testbench

    logic [XLEN-1:0]        rf  [32];    // shadow registers
    logic [XLEN-1:0]        ram [DMEM_WORDS];
    logic [6:0]             opc;
    logic [2:0]             f3;
    logic [XLEN-1:0]        a, b, op2, imm_i, imm_s, imm_b, imm_j;
    logic [XLEN-1:0]        alu_exp, wdata_exp, addr;
    logic signed [XLEN-1:0] sra_res;
    logic                   is_alu, is_load, is_store, is_br, is_jump;
    logic                   br_hold, redirect;
    logic [PC_WIDTH-1:0]    target, seq_pc_q, target_q;
    logic                   seq_q, redirect_q;

    initial begin
        for (int i = 0; i < 32; i++)
            rf[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            ram[i] = '0;    // RAM powers up cleared
    end

    // field extraction straight from the ISA formats
    assign opc   = instr_i[6:0];
    assign f3    = instr_i[14:12];
    assign a     = rf[instr_i[19:15]];    // rf[0] is never written
    assign b     = rf[instr_i[24:20]];
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    assign is_alu   = (opc == 7'h37) || (opc == 7'h13) || (opc == 7'h33);
    assign is_load  = (opc == 7'h03) && (f3 == 3'b010);
    assign is_store = (opc == 7'h23) && (f3 == 3'b010);
    assign is_br    = (opc == 7'h63) && !f3[1];    // no unsigned forms
    assign is_jump  = (opc == 7'h6f) || (opc == 7'h67);

    assign op2     = (opc == 7'h33) ? b : imm_i;
    assign sra_res = $signed(a) >>> op2[4:0];
    assign addr    = a + (is_store ? imm_s : imm_i);    // also the jalr sum

    always_comb begin
        case (f3)
            3'b000:  alu_exp = ((opc == 7'h33) && instr_i[30]) ? a - op2 : a + op2;
            3'b001:  alu_exp = a << op2[4:0];
            3'b010:  alu_exp = XLEN'($signed(a) < $signed(op2));
            3'b100:  alu_exp = a ^ op2;
            3'b101:  alu_exp = instr_i[30] ? sra_res : a >> op2[4:0];
            3'b110:  alu_exp = a | op2;
            default: alu_exp = a & op2;
        endcase
        if (opc == 7'h37)
            alu_exp = {instr_i[31:12], 12'b0};    // lui
    end

    always_comb begin
        case (f3)
            3'b000:  br_hold = (a == b);
            3'b001:  br_hold = (a != b);
            3'b100:  br_hold = ($signed(a) < $signed(b));
            default: br_hold = ($signed(a) >= $signed(b));
        endcase
    end

    always_comb begin
        if (opc == 7'h67)
            target = {addr[PC_WIDTH-1:1], 1'b0};
        else if (opc == 7'h6f)
            target = pc_i + imm_j[PC_WIDTH-1:0];
        else
            target = pc_i + imm_b[PC_WIDTH-1:0];
    end
    assign redirect = is_jump || (is_br && br_hold);

    always_comb begin
        if (is_jump)
            wdata_exp = XLEN'(pc_i) + 32'd4;    // link
        else if (is_load)
            wdata_exp = ram[addr[AW+1:2]];
        else
            wdata_exp = alu_exp;
    end

    always @(posedge clk_i) begin
        if (valid_i && we_i && (rd_i != 5'd0))
            rf[rd_i] <= wdata_i;
        if (dmem_we_i)
            ram[dmem_addr_i[AW+1:2]] <= dmem_wdata_i;
        seq_q      <= valid_i && !redirect;
        redirect_q <= valid_i && redirect;
        seq_pc_q   <= pc_i + PC_WIDTH'(4);
        target_q   <= target;
    end

    task automatic value_error(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        err_count++;
        $error("ERR %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic rule_error(input string what);
        err_count++;
        $error("%s", what);
    endtask

    a_reset_idle: assert property (@(posedge clk_i) !rst_n_i |=> !valid_i)
        else rule_error("retire_valid_o was high right after a reset cycle");

    a_first_pc: assert property (@(posedge clk_i) $rose(valid_i) |-> pc_i == RESET_PC)
        else value_error("retire_pc_o", XLEN'($sampled(pc_i)), XLEN'(RESET_PC));

    a_seq_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        seq_q |-> pc_i == seq_pc_q)
        else value_error("retire_pc_o", XLEN'($sampled(pc_i)), XLEN'($sampled(seq_pc_q)));

    a_redirect_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_q |-> pc_i == target_q)
        else value_error("retire_pc_o", XLEN'($sampled(pc_i)), XLEN'($sampled(target_q)));

    a_wdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && (is_alu || is_jump || is_load) |-> wdata_i == wdata_exp)
        else value_error("retire_wdata_o", $sampled(wdata_i), $sampled(wdata_exp));

    a_x0_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && (rd_i == 5'd0) |-> !we_i)
        else value_error("retire_we_o", XLEN'($sampled(we_i)), 32'd0);

    a_store_we: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && is_store |-> dmem_we_i)
        else value_error("dmem_we_o", XLEN'($sampled(dmem_we_i)), 32'd1);

    a_store_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && is_store |-> dmem_addr_i == addr[PC_WIDTH-1:0])
        else value_error("dmem_addr_o", XLEN'($sampled(dmem_addr_i)), $sampled(addr));

    a_store_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && is_store |-> dmem_wdata_i == b)
        else value_error("dmem_wdata_o", $sampled(dmem_wdata_i), $sampled(b));

endmodule

bind cpu_top cpu_props u_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (retire_valid_o),
    .pc_i         (retire_pc_o),
    .instr_i      (retire_instr_o),
    .we_i         (retire_we_o),
    .rd_i         (retire_rd_o),
    .wdata_i      (retire_wdata_o),
    .dmem_we_i    (dmem_we_o),
    .dmem_addr_i  (dmem_addr_o),
    .dmem_wdata_i (dmem_wdata_o)
);

// File: verification/cpu_tb.sv
// runs program.hex up to its jump-to-self; all value checks are the assertions in cpu_props
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_cfg_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic                clk;
    logic                rst_n;
    logic                retire_valid;
    logic [PC_WIDTH-1:0] retire_pc;
    logic [XLEN-1:0]     retire_instr;
    logic                retire_we;
    logic [4:0]          retire_rd;
    logic [XLEN-1:0]     retire_wdata;
    logic                dmem_we;
    logic [PC_WIDTH-1:0] dmem_addr;
    logic [XLEN-1:0]     dmem_wdata;

    cpu_top DUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_instr_o (retire_instr),
        .retire_we_o    (retire_we),
        .retire_rd_o    (retire_rd),
        .retire_wdata_o (retire_wdata),
        .dmem_we_o      (dmem_we),
        .dmem_addr_o    (dmem_addr),
        .dmem_wdata_o   (dmem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;    // 40 ns period
    end

    initial begin
        logic [PC_WIDTH-1:0] prev_pc;
        logic                seen;
        logic                halted;
        int                  cycles;
        int                  tail;

        rst_n   = 1'b0;
        prev_pc = '0;
        seen    = 1'b0;
        halted  = 1'b0;
        cycles  = 0;
        tail    = 0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        // two retires at one pc mean the halt loop was reached
        while (!halted && (DUT.u_props.err_count == 0) && (cycles < MAX_CYCLES)) begin
            @(negedge clk);    // trace is settled mid-cycle
            cycles++;
            if (retire_valid) begin
                halted  = seen && (retire_pc == prev_pc);
                seen    = 1'b1;
                prev_pc = retire_pc;
            end
        end

        // checks of the halt instruction itself
        while (halted && (DUT.u_props.err_count == 0) && (tail < 2)) begin
            @(negedge clk);
            tail++;
        end

        if (halted && (DUT.u_props.err_count == 0)) begin
            $display("All tests passed");
            $finish;
        end else begin
            if (DUT.u_props.err_count != 0)
                $display("an assertion in cpu_props failed, see the error above");
            else
                $display("core did not reach the halt loop within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

// File: verification/program.hex
// one RV32I instruction word per line from address 0, assembly in the trailing comment
123450B7 // 00 lui  x1, 0x12345
06400113 // 04 addi x2, x0, 100
FF900193 // 08 addi x3, x0, -7
0F01F213 // 0c andi x4, x3, 0x0f0
70016293 // 10 ori  x5, x2, 0x700
FFF1C313 // 14 xori x6, x3, -1
0011A393 // 18 slti x7, x3, 1
00208433 // 1c add  x8, x1, x2
403104B3 // 20 sub  x9, x2, x3
0030F533 // 24 and  x10, x1, x3
003165B3 // 28 or   x11, x2, x3
00314633 // 2c xor  x12, x2, x3
0021A6B3 // 30 slt  x13, x3, x2
00611733 // 34 sll  x14, x2, x6
0061D7B3 // 38 srl  x15, x3, x6
4061D833 // 3c sra  x16, x3, x6
00812423 // 40 sw   x8, 8(x2)
00812883 // 44 lw   x17, 8(x2)
00C12903 // 48 lw   x18, 12(x2)  never written
00510013 // 4c addi x0, x2, 5
00888463 // 50 beq  x17, x8, +8  taken
00100993 // 54 addi x19, x0, 1   skipped
00211463 // 58 bne  x2, x2, +8   not taken
0021C463 // 5c blt  x3, x2, +8   taken
00200993 // 60 addi x19, x0, 2   skipped
0021D463 // 64 bge  x3, x2, +8   not taken
00315463 // 68 bge  x2, x3, +8   taken
00300993 // 6c addi x19, x0, 3   skipped
00800A6F // 70 jal  x20, +8
00400993 // 74 addi x19, x0, 4   skipped
08500A93 // 78 addi x21, x0, 0x85
000A8B67 // 7c jalr x22, 0(x21)  lands on 0x84
00500993 // 80 addi x19, x0, 5   skipped
0000006F // 84 jal  x0, 0        halt
